// File: Makefile
# Verilator build and run of the sysctrl testbench

VERILATOR ?= verilator
TOP       ?= tb_sysctrl
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

FAIL_MSG  := ** FAIL **
PASS_MSG  := ** PASS **
SRCS      := $(filter-out +%,$(shell cat $(FLIST)))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "test failed"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "test failed, run ended without a result"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
hw/sysctrl_pkg.sv
hw/sysctrl_wb_adapter.sv
hw/sysctrl_regs.sv
hw/sysctrl_pad_route.sv
hw/sysctrl_top.sv
tb/sysctrl_checker.sv
tb/tb_sysctrl.sv

// File: hw/sysctrl_pad_route.sv
`default_nettype none
`timescale 1ns/1ns

module sysctrl_pad_route (
    input  wire logic                       clk,
    input  wire logic                       resetn,

    input  wire sysctrl_pkg::sysctrl_ctrl_t ctrl_i,

    input  wire logic                       pll_clk_i,
    input  wire logic                       trap_i,
    input  wire logic [1:0]                 gpio_out_i,
    input  wire logic [1:0]                 pad_in_i,

    output      logic [1:0]                 pad_out_o,
    output      logic                       irq7_o,
    output      logic                       irq8_o
);

    logic [1:0] sync1_q;  // first stage, may go metastable
    logic [1:0] sync2_q;

    // output pads, combinational from the controls
    always_comb begin
        pad_out_o[0] = ctrl_i.pll_dest  ? pll_clk_i : gpio_out_i[0];
        pad_out_o[1] = ctrl_i.trap_dest ? trap_i    : gpio_out_i[1];
    end

    // two-flop synchronizer for both pad inputs
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sync1_q <= 2'b00;
            sync2_q <= 2'b00;
        end else begin
            sync1_q <= pad_in_i;
            sync2_q <= sync1_q;
        end
    end

    assign irq7_o = sync2_q[0] && ctrl_i.irq7_src;  // pad 0 feeds irq 7
    assign irq8_o = sync2_q[1] && ctrl_i.irq8_src;  // pad 1 feeds irq 8

endmodule

`default_nettype wire

// File: hw/sysctrl_pkg.sv
`default_nettype none

package sysctrl_pkg;

    // bus address or data word
    typedef logic [31:0] word_t;

    // byte lane select, also used as write strobe
    typedef logic [3:0] byte_sel_t;

    // register offset inside the 256-byte window
    typedef logic [7:0] reg_off_t;

    // one request from the bus adapter to the register block
    typedef struct packed {
        word_t     addr;
        byte_sel_t wstrb;  // all zero for a read
        word_t     wdata;
    } iomem_req_t;

    // routing controls, one bit each
    typedef struct packed {
        logic pll_dest;   // pad 0 carries the pll clock
        logic trap_dest;  // pad 1 carries trap
        logic irq7_src;   // irq 7 taken from pad 0
        logic irq8_src;   // irq 8 taken from pad 1
    } sysctrl_ctrl_t;

endpackage

`default_nettype wire

// File: hw/sysctrl_regs.sv
`default_nettype none
`timescale 1ns/1ns

module sysctrl_regs #(
    parameter sysctrl_pkg::word_t    BASE_ADR = 32'h2F00_0000,
    parameter sysctrl_pkg::reg_off_t PLL_OUT  = 8'h0c,
    parameter sysctrl_pkg::reg_off_t TRAP_OUT = 8'h10,
    parameter sysctrl_pkg::reg_off_t IRQ7_SRC = 8'h14,
    parameter sysctrl_pkg::reg_off_t IRQ8_SRC = 8'h18
) (
    input  wire logic                     clk,
    input  wire logic                     resetn,

    input  wire logic                     req_valid_i,
    input  wire sysctrl_pkg::iomem_req_t  req_i,
    output      logic                     req_ready_o,
    output      sysctrl_pkg::word_t       rdata_o,

    output      sysctrl_pkg::sysctrl_ctrl_t ctrl_o
);

    sysctrl_pkg::reg_off_t      offset;
    logic                       in_window;
    logic                       accept;
    logic                       pll_sel;
    logic                       trap_sel;
    logic                       irq7_sel;
    logic                       irq8_sel;
    logic                       wr_en;
    logic                       rd_bit;
    logic                       ready_q;
    sysctrl_pkg::word_t         rdata_q;
    sysctrl_pkg::sysctrl_ctrl_t ctrl_q;

    assign offset    = req_i.addr[7:0];
    assign in_window = (req_i.addr[31:8] == BASE_ADR[31:8]);

    // ready low keeps a held request from being taken twice
    assign accept = req_valid_i && !ready_q && in_window;

    assign pll_sel  = (offset == PLL_OUT);
    assign trap_sel = (offset == TRAP_OUT);
    assign irq7_sel = (offset == IRQ7_SRC);
    assign irq8_sel = (offset == IRQ8_SRC);

    assign wr_en = accept && req_i.wstrb[0];  // only byte lane 0 is writable

    // old value of the addressed control, zero when unmapped
    always_comb begin
        if (pll_sel) begin
            rd_bit = ctrl_q.pll_dest;
        end else if (trap_sel) begin
            rd_bit = ctrl_q.trap_dest;
        end else if (irq7_sel) begin
            rd_bit = ctrl_q.irq7_src;
        end else if (irq8_sel) begin
            rd_bit = ctrl_q.irq8_src;
        end else begin
            rd_bit = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready_q <= 1'b0;
            ctrl_q  <= '0;
        end else begin
            ready_q <= accept;  // one-cycle pulse per accepted request
            if (wr_en) begin
                if (pll_sel) begin
                    ctrl_q.pll_dest <= req_i.wdata[0];
                end else if (trap_sel) begin
                    ctrl_q.trap_dest <= req_i.wdata[0];
                end else if (irq7_sel) begin
                    ctrl_q.irq7_src <= req_i.wdata[0];
                end else if (irq8_sel) begin
                    ctrl_q.irq8_src <= req_i.wdata[0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= {31'd0, rd_bit};
        end
    end

    assign req_ready_o = ready_q;
    assign rdata_o     = rdata_q;
    assign ctrl_o      = ctrl_q;

endmodule

`default_nettype wire

// File: hw/sysctrl_top.sv
`default_nettype none
`timescale 1ns/1ns

module sysctrl_top #(
    parameter sysctrl_pkg::word_t    BASE_ADR = 32'h2F00_0000,
    parameter sysctrl_pkg::reg_off_t PLL_OUT  = 8'h0c,
    parameter sysctrl_pkg::reg_off_t TRAP_OUT = 8'h10,
    parameter sysctrl_pkg::reg_off_t IRQ7_SRC = 8'h14,
    parameter sysctrl_pkg::reg_off_t IRQ8_SRC = 8'h18
) (
    input  wire logic                       clk,
    input  wire logic                       resetn,

    input  wire logic                       wb_cyc_i,
    input  wire logic                       wb_stb_i,
    input  wire logic                       wb_we_i,
    input  wire sysctrl_pkg::byte_sel_t     wb_sel_i,
    input  wire sysctrl_pkg::word_t         wb_adr_i,
    input  wire sysctrl_pkg::word_t         wb_dat_i,
    output      logic                       wb_ack_o,
    output      sysctrl_pkg::word_t         wb_dat_o,

    input  wire logic                       pll_clk_i,
    input  wire logic                       trap_i,
    input  wire logic [1:0]                 gpio_out_i,
    input  wire logic [1:0]                 pad_in_i,
    output      logic [1:0]                 pad_out_o,
    output      logic                       irq7_o,
    output      logic                       irq8_o,

    output      sysctrl_pkg::sysctrl_ctrl_t ctrl_o
);

    logic                    req_valid;
    sysctrl_pkg::iomem_req_t req;
    logic                    req_ready;
    sysctrl_pkg::word_t      rdata;

    sysctrl_wb_adapter adapter_i (
        .clk         (clk),
        .resetn      (resetn),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_sel_i    (wb_sel_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .req_valid_o (req_valid),
        .req_o       (req),
        .req_ready_i (req_ready),
        .rdata_i     (rdata)
    );

    sysctrl_regs #(
        .BASE_ADR (BASE_ADR),
        .PLL_OUT  (PLL_OUT),
        .TRAP_OUT (TRAP_OUT),
        .IRQ7_SRC (IRQ7_SRC),
        .IRQ8_SRC (IRQ8_SRC)
    ) regs_i (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .rdata_o     (rdata),
        .ctrl_o      (ctrl_o)
    );

    // controls go straight from the register block to the router
    sysctrl_pad_route route_i (
        .clk        (clk),
        .resetn     (resetn),
        .ctrl_i     (ctrl_o),
        .pll_clk_i  (pll_clk_i),
        .trap_i     (trap_i),
        .gpio_out_i (gpio_out_i),
        .pad_in_i   (pad_in_i),
        .pad_out_o  (pad_out_o),
        .irq7_o     (irq7_o),
        .irq8_o     (irq8_o)
    );

endmodule

`default_nettype wire

// File: hw/sysctrl_wb_adapter.sv
`default_nettype none
`timescale 1ns/1ns

module sysctrl_wb_adapter (
    input  wire logic                     clk,
    input  wire logic                     resetn,

    input  wire logic                     wb_cyc_i,
    input  wire logic                     wb_stb_i,
    input  wire logic                     wb_we_i,
    input  wire sysctrl_pkg::byte_sel_t   wb_sel_i,
    input  wire sysctrl_pkg::word_t       wb_adr_i,
    input  wire sysctrl_pkg::word_t       wb_dat_i,
    output      logic                     wb_ack_o,
    output      sysctrl_pkg::word_t       wb_dat_o,

    output      logic                     req_valid_o,
    output      sysctrl_pkg::iomem_req_t  req_o,
    input  wire logic                     req_ready_i,
    input  wire sysctrl_pkg::word_t       rdata_i
);

    logic                   valid;
    logic                   access_q;  // access started, response not yet seen
    sysctrl_pkg::byte_sel_t wstrb;

    assign valid = wb_cyc_i && wb_stb_i;
    assign wstrb = wb_sel_i & {4{wb_we_i}};  // reads carry no strobe

    always_ff @(posedge clk) begin
        if (!resetn) begin
            access_q <= 1'b0;
        end else begin
            // a held strobe in the ready cycle belongs to the same access
            access_q <= valid && !req_ready_i;
        end
    end

    assign req_valid_o = valid;

    always_comb begin
        req_o.addr  = wb_adr_i;
        req_o.wstrb = wstrb;
        req_o.wdata = wb_dat_i;
    end

    // ack only for a response to an access this adapter started
    assign wb_ack_o = req_ready_i && access_q;
    assign wb_dat_o = rdata_i;

endmodule

`default_nettype wire

// File: tb/sysctrl_checker.sv
`default_nettype none
`timescale 1ns/1ns

module sysctrl_checker (
    input  wire logic                       clk,
    input  wire logic                       resetn,
    input  wire logic                       wb_cyc_i,
    input  wire logic                       wb_stb_i,
    input  wire logic                       wb_ack_i,
    input  wire sysctrl_pkg::sysctrl_ctrl_t ctrl_i
);

    // ack is a single-cycle pulse
    ack_pulse: assert property (
        @(posedge clk) disable iff (!resetn) wb_ack_i |=> !wb_ack_i
    ) else $error("wb_ack_o stayed high for two cycles");

    // the slave only answers a live bus cycle
    ack_in_cycle: assert property (
        @(posedge clk) disable iff (!resetn) wb_ack_i |-> (wb_cyc_i && wb_stb_i)
    ) else $error("wb_ack_o high without cyc and stb");

    // registers clear on the reset edge
    reset_state: assert property (
        @(posedge clk) !resetn |=> (!wb_ack_i && (ctrl_i == '0))
    ) else $error("ack or controls not cleared by reset");

endmodule

bind sysctrl_top sysctrl_checker checker_i (
    .clk      (clk),
    .resetn   (resetn),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .ctrl_i   (ctrl_o)
);

`default_nettype wire

// File: tb/tb_sysctrl.sv
`default_nettype none
`timescale 1ns/1ns

module tb_sysctrl;

    localparam sysctrl_pkg::word_t    WIN_BASE      = 32'h2F00_0000;
    localparam sysctrl_pkg::reg_off_t OFF_PLL       = 8'h0c;
    localparam sysctrl_pkg::reg_off_t OFF_TRAP      = 8'h10;
    localparam sysctrl_pkg::reg_off_t OFF_IRQ7      = 8'h14;
    localparam sysctrl_pkg::reg_off_t OFF_IRQ8      = 8'h18;
    localparam sysctrl_pkg::word_t    LFSR_SEED     = 32'hbcb2_0fc1;
    localparam int                    ACK_TIMEOUT   = 16;
    localparam int                    NO_ACK_CYCLES = 8;

    logic                       clk;
    logic                       resetn;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    sysctrl_pkg::byte_sel_t     wb_sel;
    sysctrl_pkg::word_t         wb_adr;
    sysctrl_pkg::word_t         wb_dat_w;
    logic                       wb_ack;
    sysctrl_pkg::word_t         wb_dat_r;
    logic                       pll_clk;
    logic                       trap;
    logic [1:0]                 gpio_out;
    logic [1:0]                 pad_in;
    logic [1:0]                 pad_out;
    logic                       irq7;
    logic                       irq8;
    sysctrl_pkg::sysctrl_ctrl_t ctrl;

    sysctrl_pkg::word_t         lfsr_q;
    sysctrl_pkg::sysctrl_ctrl_t model_ctrl;  // expected control bits
    sysctrl_pkg::word_t         exp_rdata_q[$];
    sysctrl_pkg::sysctrl_ctrl_t exp_ctrl_q[$];
    sysctrl_pkg::word_t         cmp_rdata;
    sysctrl_pkg::sysctrl_ctrl_t cmp_ctrl;

    sysctrl_top dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_sel_i   (wb_sel),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_dat_w),
        .wb_ack_o   (wb_ack),
        .wb_dat_o   (wb_dat_r),
        .pll_clk_i  (pll_clk),
        .trap_i     (trap),
        .gpio_out_i (gpio_out),
        .pad_in_i   (pad_in),
        .pad_out_o  (pad_out),
        .irq7_o     (irq7),
        .irq8_o     (irq8),
        .ctrl_o     (ctrl)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_value(input string what, input sysctrl_pkg::word_t got,
                                 input sysctrl_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns: %s: got 0x%08h, expected 0x%08h",
                                $time, what, got, exp));
        end
    endtask

    function automatic sysctrl_pkg::word_t lfsr_next(input sysctrl_pkg::word_t state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hA300_0000;
        end else begin
            return state >> 1;
        end
    endfunction

    // one lfsr step per bit taken
    function automatic sysctrl_pkg::word_t rand_bits(input int nbits);
        sysctrl_pkg::word_t value;
        int                 b;
        value = '0;
        for (b = 0; b < nbits; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
        return value;
    endfunction

    function automatic sysctrl_pkg::word_t reg_addr(input sysctrl_pkg::reg_off_t off);
        return WIN_BASE | {24'd0, off};
    endfunction

    function automatic sysctrl_pkg::reg_off_t offset_of(input logic [1:0] idx);
        case (idx)
            2'd0:    return OFF_PLL;
            2'd1:    return OFF_TRAP;
            2'd2:    return OFF_IRQ7;
            default: return OFF_IRQ8;
        endcase
    endfunction

    // returns the old control bit and applies a lane 0 write to the model
    function automatic sysctrl_pkg::word_t ref_access(input sysctrl_pkg::word_t addr,
                                                      input sysctrl_pkg::byte_sel_t wstrb,
                                                      input sysctrl_pkg::word_t wdata);
        logic old_bit;
        old_bit = 1'b0;
        if (addr[31:8] == WIN_BASE[31:8]) begin
            case (addr[7:0])
                OFF_PLL: begin
                    old_bit = model_ctrl.pll_dest;
                    if (wstrb[0]) model_ctrl.pll_dest = wdata[0];
                end
                OFF_TRAP: begin
                    old_bit = model_ctrl.trap_dest;
                    if (wstrb[0]) model_ctrl.trap_dest = wdata[0];
                end
                OFF_IRQ7: begin
                    old_bit = model_ctrl.irq7_src;
                    if (wstrb[0]) model_ctrl.irq7_src = wdata[0];
                end
                OFF_IRQ8: begin
                    old_bit = model_ctrl.irq8_src;
                    if (wstrb[0]) model_ctrl.irq8_src = wdata[0];
                end
                default: old_bit = 1'b0;  // unmapped, reads zero
            endcase
        end
        return {31'd0, old_bit};
    endfunction

    function automatic logic [1:0] ref_pads(input sysctrl_pkg::sysctrl_ctrl_t c,
                                            input logic pll_v, input logic trap_v,
                                            input logic [1:0] gpio_v);
        logic [1:0] pads;
        pads[0] = c.pll_dest ? pll_v : gpio_v[0];
        pads[1] = c.trap_dest ? trap_v : gpio_v[1];
        return pads;
    endfunction

    task automatic bus_access(input sysctrl_pkg::word_t addr, input logic we,
                              input sysctrl_pkg::byte_sel_t sel,
                              input sysctrl_pkg::word_t wdata);
        int   waited;
        logic got_ack;
        exp_rdata_q.push_back(ref_access(addr, we ? sel : 4'h0, wdata));
        exp_ctrl_q.push_back(model_ctrl);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_sel   <= sel;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        waited  = 0;
        got_ack = 1'b0;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            if (wb_ack === 1'b1) got_ack = 1'b1;
            else waited++;
        end
        if (!got_ack) begin
            abort_run($sformatf("timeout: no ack for address 0x%08h inside the window", addr));
        end
        compare_value("ack latency in cycles", waited, 1);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input sysctrl_pkg::word_t addr, input sysctrl_pkg::byte_sel_t sel,
                             input sysctrl_pkg::word_t wdata);
        bus_access(addr, 1'b1, sel, wdata);
    endtask

    task automatic bus_read(input sysctrl_pkg::word_t addr);
        bus_access(addr, 1'b0, 4'hf, 32'd0);
    endtask

    task automatic access_outside(input sysctrl_pkg::word_t addr, input sysctrl_pkg::word_t wdata);
        int cycles;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_sel   <= 4'hf;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        for (cycles = 0; cycles < NO_ACK_CYCLES; cycles++) begin
            @(negedge clk);
            if (wb_ack !== 1'b0) begin
                abort_run($sformatf("ack seen for address 0x%08h outside the window", addr));
            end
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        for (cycles = 0; cycles < 2; cycles++) begin
            @(negedge clk);
            if (wb_ack !== 1'b0) abort_run("late ack after an access outside the window");
        end
        compare_value("ctrl_o after access outside the window", {28'd0, ctrl},
                      {28'd0, model_ctrl});
    endtask

    task automatic pad_sample();
        sysctrl_pkg::word_t r;
        logic [1:0]         exp_pad;
        r = rand_bits(4);
        @(posedge clk);
        pll_clk  <= r[0];
        trap     <= r[1];
        gpio_out <= r[3:2];
        @(negedge clk);
        exp_pad = ref_pads(model_ctrl, r[0], r[1], r[3:2]);
        compare_value("pad_out_o", {30'd0, pad_out}, {30'd0, exp_pad});
    endtask

    // new pad level reaches the irq lines after two edges
    task automatic irq_level(input logic [1:0] level);
        logic [1:0] old_level;
        logic [1:0] seen;
        int         k;
        old_level = pad_in;
        @(posedge clk);
        pad_in <= level;
        for (k = 0; k < 4; k++) begin
            @(negedge clk);
            seen = (k >= 2) ? level : old_level;
            compare_value("irq7_o", {31'd0, irq7}, {31'd0, seen[0] && model_ctrl.irq7_src});
            compare_value("irq8_o", {31'd0, irq8}, {31'd0, seen[1] && model_ctrl.irq8_src});
        end
    endtask

    always @(negedge clk) begin
        if (resetn && wb_ack === 1'b1) begin
            if (exp_rdata_q.size() == 0) begin
                abort_run("ack seen with no access pending");
            end else begin
                cmp_rdata = exp_rdata_q.pop_front();
                cmp_ctrl  = exp_ctrl_q.pop_front();
                compare_value("wb_dat_o", wb_dat_r, cmp_rdata);
                compare_value("ctrl_o", {28'd0, ctrl}, {28'd0, cmp_ctrl});
            end
        end
    end

    initial begin : stimulus
        sysctrl_pkg::word_t r;
        sysctrl_pkg::word_t d;
        sysctrl_pkg::word_t s;
        int                 i;
        int                 j;
        clk        = 1'b0;
        resetn     = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_sel     = 4'h0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        pll_clk    = 1'b0;
        trap       = 1'b0;
        gpio_out   = 2'b00;
        pad_in     = 2'b00;
        lfsr_q     = LFSR_SEED;
        model_ctrl = '0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        @(negedge clk);
        compare_value("ctrl_o after reset", {28'd0, ctrl}, 32'd0);
        compare_value("irq lines after reset", {30'd0, irq8, irq7}, 32'd0);
        for (i = 0; i < 4; i++) begin
            bus_read(reg_addr(offset_of(i[1:0])));
        end

        for (i = 0; i < 40; i++) begin  // random writes, then read back
            r = rand_bits(2);
            d = rand_bits(32);
            s = rand_bits(4);
            bus_write(reg_addr(offset_of(r[1:0])), s[3:0], d);
            bus_read(reg_addr(offset_of(r[1:0])));
        end

        bus_write(reg_addr(8'h00), 4'hf, 32'hffff_ffff);
        bus_read(reg_addr(8'h00));
        bus_write(reg_addr(8'h1c), 4'hf, 32'hffff_ffff);
        bus_read(reg_addr(8'h1c));
        bus_write(reg_addr(8'hfc), 4'h1, 32'h0000_0001);
        bus_read(reg_addr(8'hfc));

        access_outside(WIN_BASE + 32'h0000_010c, 32'hffff_ffff);
        access_outside(32'h2E00_0014, 32'h0000_0000);
        access_outside(32'hAF00_0018, 32'hffff_ffff);

        for (i = 0; i < 8; i++) begin
            r = rand_bits(2);
            bus_write(reg_addr(OFF_PLL), 4'h1, {31'd0, r[0]});
            bus_write(reg_addr(OFF_TRAP), 4'h1, {31'd0, r[1]});
            for (j = 0; j < 8; j++) begin
                pad_sample();
            end
        end

        for (i = 0; i < 8; i++) begin
            r = rand_bits(4);
            bus_write(reg_addr(OFF_IRQ7), 4'h1, {31'd0, r[0]});
            bus_write(reg_addr(OFF_IRQ8), 4'h1, {31'd0, r[1]});
            irq_level(r[3:2]);
            irq_level(2'b11);
            irq_level(2'b00);
        end

        @(posedge clk);
        if (exp_rdata_q.size() != 0) begin
            abort_run("accesses left without a response at the end of the run");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire
